//--- common/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

  // request opcodes as seen on the top level port
  typedef enum logic [1:0] {
    OP_NONE   = 2'd0,
    OP_READ   = 2'd1,
    OP_WRITE  = 2'd2,
    OP_INSERT = 2'd3
  } op_e;

  // one line is one word
  localparam int DATA_W = 32;
  localparam int BEN_W  = DATA_W / 8;  // one enable per byte

  // default geometry, 4 ways x 64 sets
  localparam int DEF_WAYS    = 4;
  localparam int DEF_INDEX_W = 6;
  localparam int DEF_TAG_W   = 10;

  // lru rank per way, enough for DEF_WAYS
  localparam int RANK_W = 2;

endpackage

`default_nettype wire

//--- common/dcache_way_if.sv
`timescale 1ns/1ps
`default_nettype none

// request broadcast to every way
interface dcache_way_if #(
  parameter int INDEX_W = dcache_pkg::DEF_INDEX_W,
  parameter int TAG_W   = dcache_pkg::DEF_TAG_W
);

  // request cycle
  dcache_pkg::op_e                op;
  logic [INDEX_W-1:0]             index;
  logic [TAG_W-1:0]               tag;
  logic [dcache_pkg::DATA_W-1:0]  wdata;
  logic [dcache_pkg::BEN_W-1:0]   ben;

  // one cycle later, lined up with the ram outputs
  dcache_pkg::op_e                op_q;
  logic [TAG_W-1:0]               tag_q;
  logic [dcache_pkg::DATA_W-1:0]  wdata_q;
  logic [dcache_pkg::BEN_W-1:0]   ben_q;

  modport ctrl (output op, index, tag, wdata, ben, op_q, tag_q, wdata_q, ben_q);
  modport way  (input  op, index, tag, wdata, ben, op_q, tag_q, wdata_q, ben_q);

endinterface

`default_nettype wire

//--- dcache/dcache_bank_ram.sv
`timescale 1ns/1ps
`default_nettype none

// word ram, registered address, write-first
// a write lands at the address currently read out, merging the enabled bytes
module dcache_bank_ram #(
  parameter int ADDR_W = dcache_pkg::DEF_INDEX_W
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [ADDR_W-1:0]             addr,
  input  logic                          we,
  input  logic [dcache_pkg::BEN_W-1:0]  ben,
  input  logic [dcache_pkg::DATA_W-1:0] wdata,
  output logic [dcache_pkg::DATA_W-1:0] rdata
);

  localparam int DEPTH = 2 ** ADDR_W;

  logic [dcache_pkg::DATA_W-1:0] mem [DEPTH];
  logic [ADDR_W-1:0]             addr_q;
  logic [dcache_pkg::DATA_W-1:0] merged;

  // array read through the registered address
  assign rdata = mem[addr_q];

  // byte merge of new data over the word being read
  always_comb begin
    for (int b = 0; b < dcache_pkg::BEN_W; b++) begin
      merged[8*b +: 8] = ben[b] ? wdata[8*b +: 8] : rdata[8*b +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      addr_q <= '0;
    end else begin
      addr_q <= addr;
    end
  end

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr_q] <= merged;  // old addr_q, next read sees it
    end
  end

endmodule

`default_nettype wire

//--- dcache/dcache_way.sv
`timescale 1ns/1ps
`default_nettype none

// one cache way: tag ram, valid bits, hit compare and data ram
module dcache_way #(
  parameter int INDEX_W = dcache_pkg::DEF_INDEX_W,
  parameter int TAG_W   = dcache_pkg::DEF_TAG_W
) (
  input  logic                          clk,
  input  logic                          rst,
  dcache_way_if.way                     req,
  input  logic                          fill,
  output logic                          hit,
  output logic [dcache_pkg::DATA_W-1:0] rdata
);

  localparam int SETS = 2 ** INDEX_W;

  logic [TAG_W-1:0]              tag_mem [SETS];
  logic [SETS-1:0]               valid;
  logic [INDEX_W-1:0]            idx_q;
  logic [TAG_W-1:0]              tag_rd;
  logic [dcache_pkg::DATA_W-1:0] word;
  logic                          do_fill;
  logic                          data_we;
  logic [dcache_pkg::BEN_W-1:0]  data_ben;

  assign tag_rd = tag_mem[idx_q];

  // hit only counts when a request is in its compare cycle
  assign hit = valid[idx_q] && (tag_rd == req.tag_q) &&
               (req.op_q != dcache_pkg::OP_NONE);

  assign do_fill = fill && (req.op_q == dcache_pkg::OP_INSERT);

  // write hit merges bytes, fill replaces the word
  assign data_we  = do_fill || (hit && (req.op_q == dcache_pkg::OP_WRITE));
  assign data_ben = do_fill ? '1 : req.ben_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      idx_q <= '0;
      valid <= '0;
    end else begin
      idx_q <= req.index;
      if (do_fill) begin
        valid[idx_q] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_fill) begin
      tag_mem[idx_q] <= req.tag_q;
    end
  end

  dcache_bank_ram #(
    .ADDR_W (INDEX_W)
  ) data_ram_i (
    .clk   (clk),
    .rst   (rst),
    .addr  (req.index),
    .we    (data_we),
    .ben   (data_ben),
    .wdata (req.wdata_q),
    .rdata (word)
  );

  // zero unless hit, so the top can simply OR the ways
  assign rdata = hit ? word : '0;

endmodule

`default_nettype wire

//--- dcache/dcache_lru.sv
`timescale 1ns/1ps
`default_nettype none

// per-set lru ranks, rank 0 is most recent
module dcache_lru #(
  parameter int WAYS    = dcache_pkg::DEF_WAYS,
  parameter int INDEX_W = dcache_pkg::DEF_INDEX_W
) (
  input  logic               clk,
  input  logic               rst,
  input  logic [INDEX_W-1:0] index,
  input  dcache_pkg::op_e    op_q,
  input  logic [WAYS-1:0]    hit,
  output logic [WAYS-1:0]    victim,
  output logic               ready
);

  localparam int SETS = 2 ** INDEX_W;
  localparam int RW   = dcache_pkg::RANK_W;

  typedef logic [WAYS-1:0][RW-1:0] rank_vec_t;

  rank_vec_t          rank_mem [SETS];
  rank_vec_t          ranks;
  rank_vec_t          new_ranks;
  rank_vec_t          init_ranks;
  logic [INDEX_W-1:0] idx_q;
  logic [INDEX_W-1:0] sweep_cnt;
  logic               sweeping;
  logic [WAYS-1:0]    touched;
  logic [RW-1:0]      touched_rank;
  logic               touch;

  assign ranks = rank_mem[idx_q];
  assign ready = !sweeping;

  // oldest way is the one at the top rank
  always_comb begin
    for (int i = 0; i < WAYS; i++) begin
      victim[i] = (ranks[i] == RW'(WAYS - 1));
    end
  end

  // misses on read/write leave ranks alone
  assign touch = (op_q == dcache_pkg::OP_INSERT) ||
                 (((op_q == dcache_pkg::OP_READ) || (op_q == dcache_pkg::OP_WRITE)) && |hit);
  assign touched = |hit ? hit : victim;

  always_comb begin
    touched_rank = '0;
    for (int i = 0; i < WAYS; i++) begin
      if (touched[i]) begin
        touched_rank = touched_rank | ranks[i];
      end
    end
    for (int i = 0; i < WAYS; i++) begin
      if (touched[i]) begin
        new_ranks[i] = '0;
      end else if (ranks[i] < touched_rank) begin
        new_ranks[i] = ranks[i] + 1'b1;  // younger than touched, ages by one
      end else begin
        new_ranks[i] = ranks[i];
      end
    end
  end

  // way i at rank i
  always_comb begin
    for (int i = 0; i < WAYS; i++) begin
      init_ranks[i] = RW'(i);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sweeping  <= 1'b1;
      sweep_cnt <= '0;
      idx_q     <= '0;
    end else begin
      idx_q <= index;
      if (sweeping) begin
        sweep_cnt <= sweep_cnt + 1'b1;
        if (sweep_cnt == '1) begin
          sweeping <= 1'b0;  // last set written
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sweeping) begin
      rank_mem[sweep_cnt] <= init_ranks;
    end else if (touch) begin
      rank_mem[idx_q] <= new_ranks;
    end
  end

endmodule

`default_nettype wire

//--- hw/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
  parameter int WAYS    = dcache_pkg::DEF_WAYS,
  parameter int INDEX_W = dcache_pkg::DEF_INDEX_W,
  parameter int TAG_W   = dcache_pkg::DEF_TAG_W
) (
  input  logic                          clk,
  input  logic                          rst,
  input  dcache_pkg::op_e               op,
  input  logic [TAG_W+INDEX_W-1:0]      addr,
  input  logic [dcache_pkg::DATA_W-1:0] wdata,
  input  logic [dcache_pkg::BEN_W-1:0]  ben,
  output logic                          ready,
  output logic                          rsp_valid,
  output logic                          rsp_hit,
  output logic [dcache_pkg::DATA_W-1:0] rsp_data
);

  // lru ranks only cover a power-of-two way count
  if (WAYS != 2 ** dcache_pkg::RANK_W) begin : g_bad_ways
    $error("dcache_top: WAYS must equal 2**RANK_W");
  end

  dcache_way_if #(
    .INDEX_W (INDEX_W),
    .TAG_W   (TAG_W)
  ) req_if ();

  logic [WAYS-1:0]             hit_vec;
  logic [WAYS-1:0]             victim;
  logic [WAYS-1:0]             fill_vec;
  logic [dcache_pkg::DATA_W-1:0] way_rdata [WAYS];
  logic [dcache_pkg::DATA_W-1:0] data_chain [WAYS+1];
  logic [WAYS:0]               hit_chain;
  logic                        any_hit;

  // request stage, ignored until the lru sweep is done
  assign req_if.op    = ready ? op : dcache_pkg::OP_NONE;
  assign req_if.index = addr[INDEX_W-1:0];
  assign req_if.tag   = addr[INDEX_W +: TAG_W];
  assign req_if.wdata = wdata;
  assign req_if.ben   = ben;

  always_ff @(posedge clk) begin
    if (rst) begin
      req_if.op_q <= dcache_pkg::OP_NONE;
    end else begin
      req_if.op_q <= req_if.op;
    end
  end

  always_ff @(posedge clk) begin
    req_if.tag_q   <= req_if.tag;
    req_if.wdata_q <= req_if.wdata;
    req_if.ben_q   <= req_if.ben;
  end

  assign data_chain[0] = '0;
  assign hit_chain[0]  = 1'b0;

  for (genvar w = 0; w < WAYS; w++) begin : g_way
    dcache_way #(
      .INDEX_W (INDEX_W),
      .TAG_W   (TAG_W)
    ) way_i (
      .clk   (clk),
      .rst   (rst),
      .req   (req_if.way),
      .fill  (fill_vec[w]),
      .hit   (hit_vec[w]),
      .rdata (way_rdata[w])
    );

    assign data_chain[w+1] = data_chain[w] | way_rdata[w];
    assign hit_chain[w+1]  = hit_chain[w] | hit_vec[w];
  end

  assign any_hit = hit_chain[WAYS];

  // insert reuses a resident line, else takes the lru way
  assign fill_vec = any_hit ? hit_vec : victim;

  dcache_lru #(
    .WAYS    (WAYS),
    .INDEX_W (INDEX_W)
  ) lru_i (
    .clk    (clk),
    .rst    (rst),
    .index  (req_if.index),
    .op_q   (req_if.op_q),
    .hit    (hit_vec),
    .victim (victim),
    .ready  (ready)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid <= 1'b0;
      rsp_hit   <= 1'b0;
      rsp_data  <= '0;
    end else begin
      rsp_valid <= (req_if.op_q != dcache_pkg::OP_NONE);
      rsp_hit   <= any_hit;
      rsp_data  <= (req_if.op_q == dcache_pkg::OP_READ) ? data_chain[WAYS] : '0;
    end
  end

endmodule

`default_nettype wire

//--- dv/dcache_assertions.sv
`timescale 1ns/1ps
`default_nettype none

// protocol checks on the cache top level
module dcache_assertions #(
  parameter int WAYS = dcache_pkg::DEF_WAYS
) (
  input logic            clk,
  input logic            rst,
  input logic            ready,
  input logic            rsp_valid,
  input logic [WAYS-1:0] hit_vec
);

  // a tag is resident in one way of its set at most
  a_one_hit : assert property (@(posedge clk) disable iff (rst) $onehot0(hit_vec))
    else $error("more than one way hit in the same cycle");

  a_rsp_ready : assert property (@(posedge clk) disable iff (rst) rsp_valid |-> ready)
    else $error("response seen while ready is low");

  // no back-pressure once the sweep is over
  a_ready_stays : assert property (@(posedge clk) disable iff (rst) ready |=> ready)
    else $error("ready fell after it had risen");

endmodule

bind dcache_top dcache_assertions #(
  .WAYS (WAYS)
) assertions_i (
  .clk       (clk),
  .rst       (rst),
  .ready     (ready),
  .rsp_valid (rsp_valid),
  .hit_vec   (hit_vec)
);

`default_nettype wire

//--- dv/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

  localparam int INDEX_W = dcache_pkg::DEF_INDEX_W;
  localparam int TAG_W   = dcache_pkg::DEF_TAG_W;
  localparam int ADDR_W  = TAG_W + INDEX_W;
  localparam int SWEEP   = 2 ** INDEX_W;
  localparam int GAP     = 2;    // idle cycles between tests
  localparam int MARGIN  = 100;

  logic                          clk;
  logic                          rst;
  dcache_pkg::op_e               op;
  logic [ADDR_W-1:0]             addr;
  logic [dcache_pkg::DATA_W-1:0] wdata;
  logic [dcache_pkg::BEN_W-1:0]  ben;
  logic                          ready;
  logic                          rsp_valid;
  logic                          rsp_hit;
  logic [dcache_pkg::DATA_W-1:0] rsp_data;

  // one entry per stimulus line
  int                            q_test[$];
  logic [1:0]                    q_op[$];
  logic [ADDR_W-1:0]             q_addr[$];
  logic [dcache_pkg::DATA_W-1:0] q_wdata[$];
  logic [dcache_pkg::BEN_W-1:0]  q_ben[$];
  logic                          q_hit[$];
  logic [dcache_pkg::DATA_W-1:0] q_data[$];
  int                            slots[$];  // line index per cycle, -1 when idle

  int limit = 100000;
  int cycles;
  int checks;
  int test_err;
  int total_err;
  int tests_run;
  int tests_failed;
  bit load_ok;

  dcache_top dut_i (
    .clk       (clk),
    .rst       (rst),
    .op        (op),
    .addr      (addr),
    .wdata     (wdata),
    .ben       (ben),
    .ready     (ready),
    .rsp_valid (rsp_valid),
    .rsp_hit   (rsp_hit),
    .rsp_data  (rsp_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, run went past %0d cycles", limit);
    $display("CHECKS FAILED");
    $finish;
  end

  task automatic load_stimulus(output bit ok);
    int                            fd;
    int                            n;
    int                            t;
    int                            prev;
    logic [1:0]                    o;
    logic [ADDR_W-1:0]             a;
    logic [dcache_pkg::DATA_W-1:0] wd;
    logic [dcache_pkg::DATA_W-1:0] ed;
    logic [dcache_pkg::BEN_W-1:0]  b;
    logic                          eh;
    logic [8*120-1:0]              line;
    ok = 1'b0;
    prev = -1;
    fd = $fopen("dv/dcache_stimulus.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = '0;
        n = $fgets(line, fd);
        n = $sscanf(line, "%d %h %h %h %h %h %h", t, o, a, wd, b, eh, ed);
        if (n == 7) begin  // comment and blank lines fall through
          if (prev >= 0 && t != prev) begin
            repeat (GAP) slots.push_back(-1);
          end
          slots.push_back(q_test.size());
          q_test.push_back(t);
          q_op.push_back(o);
          q_addr.push_back(a);
          q_wdata.push_back(wd);
          q_ben.push_back(b);
          q_hit.push_back(eh);
          q_data.push_back(ed);
          prev = t;
        end
      end
      $fclose(fd);
      ok = (q_test.size() > 0);
    end
  endtask

  task automatic check_value(input string name, input int test_no,
                             input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERROR %s test %0d: got 0x%0h, expected 0x%0h", name, test_no, got, exp);
      test_err++;
    end
  endtask

  task automatic reset_and_sweep;
    int n;
    rst <= 1'b1;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    n = 0;
    @(negedge clk);
    while (!ready) begin
      @(negedge clk);
      n++;
    end
    check_value("ready_delay", 1, n, SWEEP);  // counted with test 1
  endtask

  task automatic drive_slot(input int s);
    int i;
    i = (s < slots.size()) ? slots[s] : -1;
    if (i < 0) begin
      op    <= dcache_pkg::OP_NONE;
      addr  <= '0;
      wdata <= $urandom;  // filler, must be ignored
      ben   <= '0;
    end else begin
      op    <= dcache_pkg::op_e'(q_op[i]);
      addr  <= q_addr[i];
      wdata <= q_wdata[i];
      ben   <= q_ben[i];
    end
  endtask

  task automatic finish_test(input int i);
    tests_run++;
    if (test_err == 0) begin
      $display("test %0d: pass", q_test[i]);
    end else begin
      tests_failed++;
      $display("test %0d: fail with %0d errors", q_test[i], test_err);
    end
    total_err += test_err;
    test_err = 0;
  endtask

  // response of the request driven two cycles earlier
  task automatic check_slot(input int s);
    int i;
    i = slots[s];
    if (i < 0) begin
      check_value("rsp_valid", 0, rsp_valid, 1'b0);
    end else begin
      check_value("rsp_valid", q_test[i], rsp_valid, 1'b1);
      check_value("rsp_hit", q_test[i], rsp_hit, q_hit[i]);
      check_value("rsp_data", q_test[i], rsp_data, q_data[i]);
      if (i == q_test.size() - 1 || q_test[i+1] != q_test[i]) begin
        finish_test(i);
      end
    end
  endtask

  initial begin
    rst   = 1'b1;
    op    = dcache_pkg::OP_NONE;
    addr  = '0;
    wdata = '0;
    ben   = '0;
    void'($urandom(32'h696bae14));
    load_stimulus(load_ok);
    if (!load_ok) begin
      $display("could not read any request from the stimulus file");
      $display("CHECKS FAILED");
      $finish;
    end else begin
      limit = q_test.size() + SWEEP + MARGIN;
      reset_and_sweep();
      for (int c = 0; c < slots.size() + 2; c++) begin
        @(posedge clk);
        drive_slot(c);
        @(negedge clk);
        if (c >= 2) begin
          check_slot(c - 2);
        end
      end
      $display("%0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
               tests_run, tests_run - tests_failed, tests_failed, checks, total_err);
      if (total_err == 0 && tests_failed == 0) begin
        $display("ALL CHECKS PASSED");
      end else begin
        $display("CHECKS FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- dv/dcache_stimulus.txt
# test op addr wdata ben exp_hit exp_data
# test in decimal, the rest in hex; op 0 none 1 read 2 write 3 insert; addr is {tag, index}
1 1 0000 00000000 0 0 00000000
1 1 ffff 00000000 0 0 00000000
2 3 0141 11223344 f 0 00000000
2 1 0141 00000000 0 1 11223344
2 1 0181 00000000 0 0 00000000
3 3 01c2 aabbccdd f 0 00000000
3 2 01c2 11223344 5 1 00000000
3 1 01c2 00000000 0 1 aa22cc44
3 2 0202 ffffffff f 0 00000000
3 1 01c2 00000000 0 1 aa22cc44
3 1 0202 00000000 0 0 00000000
4 3 0043 40000001 f 0 00000000
4 3 0083 40000002 f 0 00000000
4 3 00c3 40000003 f 0 00000000
4 3 0103 40000004 f 0 00000000
4 3 0143 40000005 f 0 00000000
4 1 0043 00000000 0 0 00000000
4 1 0083 00000000 0 1 40000002
4 1 00c3 00000000 0 1 40000003
4 1 0103 00000000 0 1 40000004
4 1 0143 00000000 0 1 40000005
5 3 0044 50000001 f 0 00000000
5 3 0084 50000002 f 0 00000000
5 3 00c4 50000003 f 0 00000000
5 3 0104 50000004 f 0 00000000
5 1 0044 00000000 0 1 50000001
5 3 0144 50000005 f 0 00000000
5 1 0084 00000000 0 0 00000000
5 1 0044 00000000 0 1 50000001
5 1 00c4 00000000 0 1 50000003
5 1 0104 00000000 0 1 50000004
5 1 0144 00000000 0 1 50000005
6 3 0045 12345678 f 0 00000000
6 2 0045 0000abcd 3 1 00000000
6 1 0045 00000000 0 1 1234abcd
6 2 0045 ff000000 8 1 00000000
6 1 0045 00000000 0 1 ff34abcd
6 1 0085 00000000 0 0 00000000

//--- filelist.f
common/dcache_pkg.sv
common/dcache_way_if.sv
dcache/dcache_bank_ram.sv
dcache/dcache_way.sv
dcache/dcache_lru.sv
hw/dcache_top.sv
dv/dcache_assertions.sv
dv/dcache_tb.sv
